//--- design/accLinkUnit.sv
`timescale 1ns/1ps
`include "pdp8_params.svh"

module accLinkUnit import pdp8Pkg::*; (
  input  logic     CLK,
  input  logic     rstN,
  input  pdpWordT  memData,
  input  opClassT  opClass,
  input  logic     accLoadMem,
  input  logic     accClear,
  input  logic     oprExec,
  input  logic     oprGroup2,
  input  pdpWordT  oprBits,
  output pdpWordT  acc,
  output logic     link,
  output logic     skipCond
);

  // Link is the top bit of the combined values
  logic [`PDP8_WORD_W:0] tadSum;
  logic [`PDP8_WORD_W:0] incSum;
  logic [`PDP8_WORD_W:0] rotIn;
  logic [`PDP8_WORD_W:0] rotOut;
  pdpWordT               clrAc;
  pdpWordT               cmpAc;
  logic                  clrLink;
  logic                  cmpLink;
  logic                  skipRaw;

  assign tadSum = {1'b0, acc} + {1'b0, memData};

  // Group 1 chain, clear then complement then increment then rotate
  always_comb begin
    clrAc   = oprBits[7] ? '0 : acc;
    clrLink = oprBits[6] ? 1'b0 : link;
    cmpAc   = oprBits[5] ? ~clrAc : clrAc;
    cmpLink = oprBits[4] ? ~clrLink : clrLink;
    incSum  = {1'b0, cmpAc} + {{`PDP8_WORD_W{1'b0}}, oprBits[0]};
    // IAC carry flips the link
    rotIn   = {cmpLink ^ incSum[`PDP8_WORD_W], incSum[`PDP8_WORD_W-1:0]};
    // Bits are RAR, RAL and the twice or BSW bit
    case (oprBits[3:1])
      3'b100:  rotOut = {rotIn[0], rotIn[12:1]};
      3'b101:  rotOut = {rotIn[1:0], rotIn[12:2]};
      3'b010:  rotOut = {rotIn[11:0], rotIn[12]};
      3'b011:  rotOut = {rotIn[10:0], rotIn[12:11]};
      3'b001:  rotOut = {rotIn[12], rotIn[5:0], rotIn[11:6]};
      default: rotOut = rotIn;
    endcase
  end

  // SMA, SZA and SNL are ORed, sense bit 3 turns them round
  assign skipRaw  = (oprBits[6] && acc[`PDP8_WORD_W-1]) ||
                    (oprBits[5] && (acc == '0)) ||
                    (oprBits[4] && link);
  assign skipCond = oprGroup2 && (skipRaw ^ oprBits[3]);

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      acc  <= '0;
      link <= 1'b0;
    end else if (accLoadMem) begin
      if (opClass == `PDP8_OP_AND) begin
        acc <= acc & memData;
      end else if (opClass == `PDP8_OP_TAD) begin
        acc  <= tadSum[`PDP8_WORD_W-1:0];
        link <= link ^ tadSum[`PDP8_WORD_W];
      end
    end else if (accClear) begin
      // DCA leaves AC clear
      acc <= '0;
    end else if (oprExec) begin
      if (oprGroup2) begin
        // Group 2 CLA acts after the skip test
        if (oprBits[7]) begin
          acc <= '0;
        end
      end else begin
        {link, acc} <= rotOut;
      end
    end
  end

endmodule

//--- design/instDecoder.sv
`timescale 1ns/1ps
`include "pdp8_params.svh"

module instDecoder import pdp8Pkg::*; (
  input  pdpWordT  ir,
  input  pdpAddrT  pc,
  output opClassT  opClass,
  output logic     indirect,
  output logic     isOperate,
  output pdpAddrT  effAddr,
  output logic     oprGroup2,
  output pdpWordT  oprBits,
  output logic     oprHalt
);

  logic isOpr;
  logic group1;

  assign opClass = ir[`PDP8_WORD_W-1 -: `PDP8_OP_W];
  assign isOpr   = (opClass == `PDP8_OP_OPR);

  // IOT runs as an operate word with no bits
  assign isOperate = isOpr || (opClass == `PDP8_OP_IOT);

  // Bit 8 is the group bit on operate words
  assign indirect = !isOperate && ir[`PDP8_IND_BIT];

  // Page bits from PC on a current-page reference, else page zero
  assign effAddr[`PDP8_PAGE_OFS_W-1:0] = ir[`PDP8_PAGE_OFS_W-1:0];
  assign effAddr[`PDP8_WORD_W-1:`PDP8_PAGE_OFS_W] =
    ir[`PDP8_PAGE_BIT] ? pc[`PDP8_WORD_W-1:`PDP8_PAGE_OFS_W] : '0;

  // Group 3 has bit 0 set along with the group bit
  assign group1    = isOpr && !ir[`PDP8_OPR_GROUP_BIT];
  assign oprGroup2 = isOpr && ir[`PDP8_OPR_GROUP_BIT] && !ir[0];

  // Group 3 and IOT turn into a no-op
  assign oprBits = (group1 || oprGroup2) ? ir : '0;

  // HLT is bit 1 of group 2
  assign oprHalt = oprGroup2 && ir[1];

endmodule

//--- design/majorSequencer.sv
`timescale 1ns/1ps
`include "pdp8_params.svh"

module majorSequencer import pdp8Pkg::*; (
  input  logic     CLK,
  input  logic     rstN,
  input  opClassT  opClass,
  input  logic     indirect,
  input  logic     isOperate,
  input  logic     oprHalt,
  input  logic     skipCond,
  input  logic     mbZero,
  input  logic     memDone,
  output logic     memStart,
  output logic     memWrite,
  output addrSelT  addrSel,
  output logic     irLoad,
  output logic     pcInc,
  output logic     pcLoad,
  output logic     pcSkip,
  output logic     accLoadMem,
  output logic     accClear,
  output logic     oprExec,
  output logic     mbInc,
  output logic     halted,
  output logic     instDone
);

  majorStateT state;
  majorStateT stateNext;
  // Step within a major state
  logic [1:0] phase;
  logic [1:0] phaseNext;
  // Last cycle of the instruction
  logic       endInst;
  // High from memStart until memDone
  logic       memBusy;

  assign halted = (state == stHalted);

  // Once deferred, the operand address is the pointer word
  always_comb begin
    case (state)
      stDefer:                addrSel = `PDP8_ASEL_EA;
      stExecute, stWriteBack: addrSel = indirect ? `PDP8_ASEL_IND : `PDP8_ASEL_EA;
      default:                addrSel = `PDP8_ASEL_PC;
    endcase
  end

  always_comb begin
    stateNext = state;
    phaseNext = phase;
    endInst   = 1'b0;
    {memStart, memWrite, irLoad, pcInc, pcLoad, pcSkip} = '0;
    {accLoadMem, accClear, oprExec, mbInc, instDone} = '0;
    case (state)
      stReset: stateNext = stFetch;
      stFetch: begin
        if (phase == 2'd0) begin
          memStart  = 1'b1;
          phaseNext = 2'd1;
        end else if (phase == 2'd1) begin
          // Latch IR and step past the instruction
          irLoad    = memDone;
          pcInc     = memDone;
          phaseNext = memDone ? 2'd2 : 2'd1;
        end else begin
          // IR decoded by now
          phaseNext = 2'd0;
          stateNext = indirect ? stDefer : stExecute;
        end
      end
      stDefer: begin
        // Fetch the pointer word
        memStart  = (phase == 2'd0);
        phaseNext = memDone ? 2'd0 : 2'd1;
        stateNext = memDone ? stExecute : stDefer;
      end
      stExecute: begin
        if (isOperate) begin
          // Skip test sees AC before a group 2 CLA
          oprExec = 1'b1;
          pcSkip  = skipCond;
          endInst = 1'b1;
        end else begin
          case (opClass)
            `PDP8_OP_AND, `PDP8_OP_TAD: begin
              memStart   = (phase == 2'd0);
              phaseNext  = 2'd1;
              accLoadMem = memDone;
              endInst    = memDone;
            end
            `PDP8_OP_ISZ: begin
              memStart  = (phase == 2'd0);
              phaseNext = memDone ? 2'd0 : 2'd1;
              stateNext = memDone ? stWriteBack : stExecute;
            end
            `PDP8_OP_DCA: begin
              memStart  = (phase == 2'd0);
              memWrite  = (phase == 2'd0);
              phaseNext = 2'd1;
              accClear  = memDone;
              endInst   = memDone;
            end
            `PDP8_OP_JMS: begin
              // Return address written, then PC takes target plus one
              memStart = (phase == 2'd0);
              memWrite = (phase == 2'd0);
              pcLoad   = (phase == 2'd1) && memDone;
              pcInc    = (phase == 2'd2);
              endInst  = (phase == 2'd2);
              if (phase == 2'd0 || pcLoad) begin
                phaseNext = phase + 2'd1;
              end
            end
            default: begin
              // JMP waits one cycle for the target to reach the address register
              phaseNext = 2'd1;
              pcLoad    = (phase == 2'd1);
              endInst   = (phase == 2'd1);
            end
          endcase
        end
      end
      stWriteBack: begin
        // ISZ increment, write back, then skip on zero
        mbInc     = (phase == 2'd0);
        memStart  = (phase == 2'd1);
        memWrite  = (phase == 2'd1);
        pcSkip    = (phase == 2'd2) && memDone && mbZero;
        endInst   = (phase == 2'd2) && memDone;
        phaseNext = (phase == 2'd2) ? 2'd2 : phase + 2'd1;
      end
      default: stateNext = stHalted;
    endcase
    if (endInst) begin
      instDone  = 1'b1;
      phaseNext = 2'd0;
      stateNext = (isOperate && oprHalt) ? stHalted : stFetch;
    end
  end

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      state   <= stReset;
      phase   <= 2'd0;
      memBusy <= 1'b0;
    end else begin
      state <= stateNext;
      phase <= phaseNext;
      if (memStart) begin
        memBusy <= 1'b1;
      end else if (memDone) begin
        memBusy <= 1'b0;
      end
    end
  end

  // One access at a time on the memory port
  assert property (@(posedge CLK) disable iff (!rstN) memStart |-> !memBusy);

  assert property (@(posedge CLK) disable iff (!rstN) !(pcLoad && pcInc));

endmodule

//--- design/memoryPort.sv
`timescale 1ns/1ps
`include "pdp8_params.svh"

module memoryPort import pdp8Pkg::*; (
  input  logic     CLK,
  input  logic     rstN,
  input  logic     memStart,
  input  logic     memWrite,
  input  addrSelT  addrSel,
  input  pdpAddrT  pc,
  input  pdpAddrT  effAddr,
  input  pdpWordT  acc,
  input  logic     irLoad,
  input  logic     mbInc,
  input  pdpWordT  wbDatI,
  input  logic     wbAck,
  output logic     wbCyc,
  output logic     wbStb,
  output logic     wbWe,
  output pdpAddrT  wbAdr,
  output pdpWordT  wbDatO,
  output logic     memDone,
  output pdpWordT  memData,
  output pdpWordT  ir,
  output logic     mbZero
);

  // Memory buffer
  pdpWordT mb;
  // Pointer word from the last defer
  pdpAddrT indPtr;
  pdpAddrT selAddr;
  pdpWordT wrData;
  // Source of the address in flight
  addrSelT curSel;
  logic    ackRead;

  assign memData = mb;
  assign mbZero  = (mb == '0);
  assign ackRead = wbCyc && wbAck && !wbWe;

  always_comb begin
    case (addrSel)
      `PDP8_ASEL_EA:  selAddr = effAddr;
      `PDP8_ASEL_IND: selAddr = indPtr;
      default:        selAddr = pc;
    endcase
  end

  // Write data by opcode, ISZ writes back the buffer and JMS the return address
  always_comb begin
    case (ir[`PDP8_WORD_W-1 -: `PDP8_OP_W])
      `PDP8_OP_ISZ: wrData = mb;
      `PDP8_OP_JMS: wrData = pc;
      default:      wrData = acc;
    endcase
  end

  // Bus cycle control
  always_ff @(posedge CLK) begin
    if (!rstN) begin
      wbCyc   <= 1'b0;
      wbStb   <= 1'b0;
      wbWe    <= 1'b0;
      memDone <= 1'b0;
      ir      <= '0;
    end else begin
      memDone <= wbCyc && wbAck;
      if (memStart) begin
        wbCyc <= 1'b1;
        wbStb <= 1'b1;
        wbWe  <= memWrite;
      end else if (wbCyc && wbAck) begin
        wbCyc <= 1'b0;
        wbStb <= 1'b0;
        wbWe  <= 1'b0;
      end
      if (irLoad) begin
        ir <= mb;
      end
    end
  end

  // Address and data registers
  always_ff @(posedge CLK) begin
    // Address follows the select while the bus is idle
    if (!wbCyc) begin
      wbAdr <= selAddr;
    end
    if (memStart) begin
      wbDatO <= wrData;
      curSel <= addrSel;
    end
    if (ackRead) begin
      mb <= wbDatI;
      if (curSel == `PDP8_ASEL_EA) begin
        indPtr <= wbDatI;
      end
    end else if (mbInc) begin
      mb <= mb + 1'b1;
    end
  end

  assert property (@(posedge CLK) disable iff (!rstN) wbStb |-> wbCyc);

  // Request held steady until the slave acknowledges
  assert property (@(posedge CLK) disable iff (!rstN)
    wbStb && !wbAck |=> wbStb && $stable(wbAdr) && $stable(wbWe) && $stable(wbDatO));

endmodule

//--- design/pdp8Cpu.sv
`timescale 1ns/1ps

module pdp8Cpu import pdp8Pkg::*; (
  input  logic     CLK,
  input  logic     rstN,
  input  pdpWordT  wbDatI,
  input  logic     wbAck,
  output logic     wbCyc,
  output logic     wbStb,
  output logic     wbWe,
  output pdpAddrT  wbAdr,
  output pdpWordT  wbDatO,
  output pdpWordT  accOut,
  output logic     linkOut,
  output pdpAddrT  pcOut,
  output logic     halted,
  output logic     instDone
);

  // Sequencer strobes
  logic    memStart;
  logic    memWrite;
  addrSelT addrSel;
  logic    irLoad;
  logic    pcInc;
  logic    pcLoad;
  logic    pcSkip;
  logic    accLoadMem;
  logic    accClear;
  logic    oprExec;
  logic    mbInc;

  // Status back to the sequencer
  logic    memDone;
  logic    skipCond;
  logic    mbZero;

  // Decoded instruction
  pdpWordT ir;
  opClassT opClass;
  logic    indirect;
  logic    isOperate;
  logic    oprGroup2;
  logic    oprHalt;
  pdpWordT oprBits;
  pdpAddrT effAddr;
  pdpWordT memData;

  majorSequencer u_seq (
    .CLK(CLK), .rstN(rstN),
    .opClass(opClass), .indirect(indirect), .isOperate(isOperate), .oprHalt(oprHalt),
    .skipCond(skipCond), .mbZero(mbZero), .memDone(memDone),
    .memStart(memStart), .memWrite(memWrite), .addrSel(addrSel), .irLoad(irLoad),
    .pcInc(pcInc), .pcLoad(pcLoad), .pcSkip(pcSkip),
    .accLoadMem(accLoadMem), .accClear(accClear), .oprExec(oprExec), .mbInc(mbInc),
    .halted(halted), .instDone(instDone)
  );

  // Jump targets come off the address register, which holds them when idle
  programCounter u_pc (
    .CLK(CLK), .rstN(rstN),
    .pcInc(pcInc), .pcSkip(pcSkip), .pcLoad(pcLoad),
    .loadAddr(wbAdr),
    .pc(pcOut)
  );

  instDecoder u_dec (
    .ir(ir), .pc(pcOut),
    .opClass(opClass), .indirect(indirect), .isOperate(isOperate),
    .effAddr(effAddr), .oprGroup2(oprGroup2), .oprBits(oprBits), .oprHalt(oprHalt)
  );

  accLinkUnit u_acc (
    .CLK(CLK), .rstN(rstN),
    .memData(memData), .opClass(opClass),
    .accLoadMem(accLoadMem), .accClear(accClear), .oprExec(oprExec),
    .oprGroup2(oprGroup2), .oprBits(oprBits),
    .acc(accOut), .link(linkOut), .skipCond(skipCond)
  );

  memoryPort u_mem (
    .CLK(CLK), .rstN(rstN),
    .memStart(memStart), .memWrite(memWrite), .addrSel(addrSel),
    .pc(pcOut), .effAddr(effAddr), .acc(accOut), .irLoad(irLoad), .mbInc(mbInc),
    .wbDatI(wbDatI), .wbAck(wbAck),
    .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatO(wbDatO),
    .memDone(memDone), .memData(memData), .ir(ir), .mbZero(mbZero)
  );

endmodule

//--- design/pdp8Pkg.sv
`include "pdp8_params.svh"

package pdp8Pkg;

  // Data word as stored in memory or held in AC
  typedef logic [`PDP8_WORD_W-1:0] pdpWordT;

  // Full 4K word address
  typedef logic [`PDP8_WORD_W-1:0] pdpAddrT;

  // Top three bits of the instruction
  typedef logic [`PDP8_OP_W-1:0] opClassT;

  // Memory address source select
  typedef logic [1:0] addrSelT;

  // Major states of the instruction cycle
  typedef enum logic [2:0] {
    stFetch     = 3'd0,
    stDefer     = 3'd1,
    stExecute   = 3'd2,
    stWriteBack = 3'd3,
    stHalted    = 3'd4,
    stReset     = 3'd5
  } majorStateT;

endpackage

//--- design/pdp8_params.svh
`ifndef PDP8_PARAMS_SVH
`define PDP8_PARAMS_SVH

// Machine word and addressing
`define PDP8_WORD_W      12
`define PDP8_PAGE_OFS_W  7
`define PDP8_OP_W        3
// First fetch after reset
`define PDP8_START_ADDR  12'o0200

// Bit positions in the instruction word, bit 0 is the LSB
`define PDP8_OPR_GROUP_BIT  8
`define PDP8_IND_BIT        8
`define PDP8_PAGE_BIT       7

// Opcode field values
`define PDP8_OP_AND  3'o0
`define PDP8_OP_TAD  3'o1
`define PDP8_OP_ISZ  3'o2
`define PDP8_OP_DCA  3'o3
`define PDP8_OP_JMS  3'o4
`define PDP8_OP_JMP  3'o5
`define PDP8_OP_IOT  3'o6
`define PDP8_OP_OPR  3'o7

// Address source for the memory port
`define PDP8_ASEL_PC   2'd0
`define PDP8_ASEL_EA   2'd1
`define PDP8_ASEL_IND  2'd2

`endif

//--- design/programCounter.sv
`timescale 1ns/1ps
`include "pdp8_params.svh"

module programCounter import pdp8Pkg::*; (
  input  logic     CLK,
  input  logic     rstN,
  input  logic     pcInc,
  input  logic     pcSkip,
  input  logic     pcLoad,
  input  pdpAddrT  loadAddr,
  output pdpAddrT  pc
);

  pdpAddrT pcPlusOne;

  // Wraps at 4K
  assign pcPlusOne = pc + 1'b1;

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      pc <= `PDP8_START_ADDR;
    end else if (pcLoad) begin
      pc <= loadAddr;
    end else if (pcInc || pcSkip) begin
      // Skip steps over the next word
      pc <= pcPlusOne;
    end
  end

  // Sequencer never asks for two updates in one cycle
  assert property (@(posedge CLK) disable iff (!rstN) $onehot0({pcInc, pcSkip, pcLoad}));

endmodule

//--- run.sh
#!/bin/sh
# Build with Verilator, run, then scan the log for the fail line
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cpuTb -f src.f -o cpuSim \
  && ./obj_dir/cpuSim > sim.log 2>&1 \
  || { echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "Simulation ended early, see sim.log"; exit 1; }
echo "Simulation passed"

//--- src.f
+incdir+design
design/pdp8Pkg.sv
design/programCounter.sv
design/instDecoder.sv
design/accLinkUnit.sv
design/memoryPort.sv
design/majorSequencer.sv
design/pdp8Cpu.sv
tests/cpuChecker.sv
tests/cpuTb.sv

//--- tests/cpuChecker.sv
`timescale 1ns/1ps
`include "pdp8_params.svh"

module cpuChecker import pdp8Pkg::*; #(
  parameter int nameChars = 12
) (
  input  logic                   CLK,
  input  logic                   rstN,
  input  logic                   wbCyc,
  input  logic                   wbStb,
  input  logic                   wbWe,
  input  logic                   wbAck,
  input  pdpAddrT                wbAdr,
  input  pdpWordT                wbDatO,
  input  pdpWordT                accOut,
  input  logic                   linkOut,
  input  pdpAddrT                pcOut,
  input  logic                   halted,
  input  logic                   instDone,
  input  logic                   checkNow,
  input  logic [8*nameChars-1:0] testName,
  input  pdpWordT                expAcc,
  input  logic                   expLink,
  input  pdpAddrT                expPc,
  input  pdpAddrT                checkAddr,
  input  pdpWordT                expWord,
  input  pdpWordT                initWord,
  input  int                     expInsts,
  output int                     errorCount,
  output int                     checkCount
);

  int      errors = 0;
  int      checks = 0;
  // Cycles with instDone high since reset
  int      instCount;
  // Set once the CPU halts, cleared by reset
  logic    haltSeen;
  // Content of the watched address as seen from the bus
  pdpWordT shadowWord;

  assign errorCount = errors;
  assign checkCount = checks;

  task automatic compareField(input string what, input pdpWordT expVal, input pdpWordT actVal);
    checks++;
    if (actVal !== expVal) begin
      errors++;
      $display("CHECK FAILED %0s %0s: expected %04o, actual %04o",
               testName, what, expVal, actVal);
    end
  endtask

  always @(posedge CLK) begin
    if (!rstN) begin
      // Start from what the memory was loaded with
      shadowWord = initWord;
      instCount  = 0;
      haltSeen   = 1'b0;
    end else begin
      // Acknowledged write to the watched word
      if (wbCyc && wbStb && wbWe && wbAck && (wbAdr == checkAddr)) begin
        shadowWord = wbDatO;
      end
      if (instDone) begin
        instCount++;
      end
      // Only reset may leave the halted state
      if (halted) begin
        haltSeen = 1'b1;
      end else if (haltSeen) begin
        errors++;
        haltSeen = 1'b0;
        $display("Test %0s: CPU left the halted state without a reset", testName);
      end
      if (checkNow) begin
        compareField("AC", expAcc, accOut);
        compareField("link", {{(`PDP8_WORD_W-1){1'b0}}, expLink},
                     {{(`PDP8_WORD_W-1){1'b0}}, linkOut});
        compareField("PC", expPc, pcOut);
        compareField("memory word", expWord, shadowWord);
        // One instDone cycle per instruction, HLT included
        compareField("instruction count", pdpWordT'(expInsts), pdpWordT'(instCount));
      end
    end
  end

endmodule

//--- tests/cpuTb.sv
`timescale 1ns/1ps
`include "pdp8_params.svh"

module cpuTb import pdp8Pkg::*; ();

  localparam int numRows   = 11;
  localparam int maxPairs  = 8;
  localparam int nameChars = 12;
  localparam int rowCycles = 400;
  localparam int clkPeriod = 10;

  logic    CLK;
  logic    rstN;
  pdpWordT wbDatI;
  logic    wbAck;
  logic    wbCyc;
  logic    wbStb;
  logic    wbWe;
  pdpAddrT wbAdr;
  pdpWordT wbDatO;
  pdpWordT accOut;
  logic    linkOut;
  pdpAddrT pcOut;
  logic    halted;
  logic    instDone;

  // Memory model and its wait-state state
  pdpWordT     mem [0:4095];
  logic [31:0] lfsr;
  logic        reqOpen;
  int          waitLeft;

  // Test table, pairs are {address, word} with zero as unused
  logic [8*nameChars-1:0] rowName    [numRows];
  logic [23:0]            rowPairs   [numRows][maxPairs];
  pdpWordT                rowAcc     [numRows];
  logic                   rowLink    [numRows];
  pdpAddrT                rowPc      [numRows];
  pdpAddrT                rowChkAddr [numRows];
  pdpWordT                rowChkWord [numRows];
  // Instructions executed up to and including the final HLT
  int                     rowInsts   [numRows];

  // Expected values for the row in progress
  logic                   checkNow;
  logic [8*nameChars-1:0] curName;
  pdpWordT                expAcc;
  logic                   expLink;
  pdpAddrT                expPc;
  pdpAddrT                checkAddr;
  pdpWordT                expWord;
  pdpWordT                initWord;
  int                     expInsts;
  int                     errorCount;
  int                     checkCount;

  pdp8Cpu i_dut (
    .CLK(CLK), .rstN(rstN), .wbDatI(wbDatI), .wbAck(wbAck),
    .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatO(wbDatO),
    .accOut(accOut), .linkOut(linkOut), .pcOut(pcOut), .halted(halted), .instDone(instDone)
  );

  cpuChecker #(.nameChars(nameChars)) u_checker (
    .CLK(CLK), .rstN(rstN), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAck(wbAck),
    .wbAdr(wbAdr), .wbDatO(wbDatO), .accOut(accOut), .linkOut(linkOut), .pcOut(pcOut),
    .halted(halted), .instDone(instDone), .checkNow(checkNow), .testName(curName),
    .expAcc(expAcc), .expLink(expLink), .expPc(expPc), .checkAddr(checkAddr),
    .expWord(expWord), .initWord(initWord), .expInsts(expInsts),
    .errorCount(errorCount), .checkCount(checkCount)
  );

  initial begin
    CLK = 1'b0;
    forever #(clkPeriod / 2) CLK = ~CLK;
  end

  // Galois LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    lfsrStep = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // Two bits per access, 0 to 3 wait states
  task automatic drawWaitStates(output int waits);
    logic [1:0] bits;
    for (int i = 0; i < 2; i++) begin
      lfsr    = lfsrStep(lfsr);
      bits[i] = lfsr[0];
    end
    waits = bits;
  endtask

  // Wishbone slave, one ack pulse per request
  always @(posedge CLK) begin
    #1;
    if (!rstN) begin
      wbAck   = 1'b0;
      reqOpen = 1'b0;
    end else if (wbAck) begin
      wbAck = 1'b0;
    end else if (wbCyc && wbStb) begin
      if (!reqOpen) begin
        reqOpen = 1'b1;
        drawWaitStates(waitLeft);
      end
      if (waitLeft == 0) begin
        reqOpen = 1'b0;
        wbAck   = 1'b1;
        if (wbWe) begin
          mem[wbAdr] = wbDatO;
        end else begin
          wbDatI = mem[wbAdr];
        end
      end else begin
        waitLeft--;
      end
    end
  end

  task automatic setExpect(input int r, input logic [8*nameChars-1:0] name,
                           input pdpWordT acc, input logic link, input pdpAddrT pc,
                           input pdpAddrT chkAddr, input pdpWordT chkWord,
                           input int insts);
    rowName[r]    = name;
    rowAcc[r]     = acc;
    rowLink[r]    = link;
    rowPc[r]      = pc;
    rowChkAddr[r] = chkAddr;
    rowChkWord[r] = chkWord;
    rowInsts[r]   = insts;
  endtask

  // Programs in octal, each pair is address then word
  task automatic buildTable();
    rowPairs[0] = '{24'o02001050, 24'o02011051, 24'o02023052, 24'o02031050,
                    24'o02040202, 24'o02057402, 24'o00506543, 24'o00512345};
    setExpect(0, "tad_and", 12'o2042, 1'b1, 12'o0206, 12'o0052, 12'o1110, 6);
    rowPairs[1] = '{24'o02001050, 24'o02013451, 24'o02027402, 24'o00504321,
                    24'o00510060, 24'o0, 24'o0, 24'o0};
    setExpect(1, "dca_ind", 12'o0000, 1'b0, 12'o0203, 12'o0060, 12'o4321, 3);
    rowPairs[2] = '{24'o02002050, 24'o02017402, 24'o02027402, 24'o00507777,
                    24'o0, 24'o0, 24'o0, 24'o0};
    setExpect(2, "isz_skip", 12'o0000, 1'b0, 12'o0203, 12'o0050, 12'o0000, 2);
    rowPairs[3] = '{24'o02002050, 24'o02017402, 24'o02027402, 24'o00500005,
                    24'o0, 24'o0, 24'o0, 24'o0};
    setExpect(3, "isz_noskip", 12'o0000, 1'b0, 12'o0202, 12'o0050, 12'o0006, 2);
    // Subroutine returns through its entry word
    rowPairs[4] = '{24'o02004210, 24'o02017402, 24'o02100000, 24'o02111050,
                    24'o02125610, 24'o00500123, 24'o0, 24'o0};
    setExpect(4, "jms_jmp_ind", 12'o0123, 1'b0, 12'o0202, 12'o0210, 12'o0201, 4);
    rowPairs[5] = '{24'o02005204, 24'o02017402, 24'o02047341, 24'o02053050,
                    24'o02067402, 24'o00501234, 24'o0, 24'o0};
    setExpect(5, "jmp_grp1", 12'o0000, 1'b1, 12'o0207, 12'o0050, 12'o0000, 4);
    rowPairs[6] = '{24'o02001050, 24'o02017004, 24'o02023051, 24'o02031052,
                    24'o02047012, 24'o02057402, 24'o00504001, 24'o00520003};
    setExpect(6, "ral_rtr", 12'o6000, 1'b1, 12'o0206, 12'o0051, 12'o0002, 6);
    rowPairs[7] = '{24'o02001050, 24'o02017002, 24'o02023051, 24'o02031051,
                    24'o02047020, 24'o02057402, 24'o00501234, 24'o0};
    setExpect(7, "bsw_cml", 12'o3412, 1'b1, 12'o0206, 12'o0051, 12'o3412, 6);
    // A wrong skip lands on the first HLT
    rowPairs[8] = '{24'o02007440, 24'o02017402, 24'o02021050, 24'o02037440,
                    24'o02047450, 24'o02057402, 24'o02067402, 24'o00500001};
    setExpect(8, "sza_sna", 12'o0001, 1'b0, 12'o0207, 12'o0050, 12'o0001, 5);
    rowPairs[9] = '{24'o02001201, 24'o02017500, 24'o02027402, 24'o02037420,
                    24'o02047020, 24'o02057420, 24'o02067402, 24'o02077402};
    setExpect(9, "sma_snl", 12'o7500, 1'b1, 12'o0210, 12'o0201, 12'o7500, 6);
    rowPairs[10] = '{24'o02007510, 24'o02017402, 24'o02027430, 24'o02037402,
                     24'o02047040, 24'o02057700, 24'o02067402, 24'o02077402};
    setExpect(10, "spa_szl_cla", 12'o0000, 1'b0, 12'o0210, 12'o0205, 12'o7700, 5);
  endtask

  task automatic loadMemory(input int r);
    for (int a = 0; a < 4096; a++) begin
      mem[a] = pdpWordT'(a) ^ 12'o5252;
    end
    for (int p = 0; p < maxPairs; p++) begin
      if (rowPairs[r][p] != '0) begin
        mem[rowPairs[r][p][23:12]] = rowPairs[r][p][11:0];
      end
    end
  endtask

  task automatic runRow(input int r);
    @(posedge CLK);
    #1;
    rstN      = 1'b0;
    curName   = rowName[r];
    expAcc    = rowAcc[r];
    expLink   = rowLink[r];
    expPc     = rowPc[r];
    checkAddr = rowChkAddr[r];
    expWord   = rowChkWord[r];
    expInsts  = rowInsts[r];
    loadMemory(r);
    initWord  = mem[rowChkAddr[r]];
    repeat (5) @(posedge CLK);
    #1;
    rstN = 1'b1;
    // Run until the CPU halts
    do begin
      @(posedge CLK);
      #1;
    end while (!halted);
    checkNow = 1'b1;
    @(posedge CLK);
    #1;
    checkNow = 1'b0;
  endtask

  initial begin
    rstN      = 1'b0;
    wbAck     = 1'b0;
    wbDatI    = '0;
    reqOpen   = 1'b0;
    waitLeft  = 0;
    lfsr      = 32'h7196bc52;
    checkNow  = 1'b0;
    curName   = '0;
    expAcc    = '0;
    expLink   = 1'b0;
    expPc     = '0;
    checkAddr = '0;
    expWord   = '0;
    initWord  = '0;
    expInsts  = 0;
    buildTable();
    for (int r = 0; r < numRows; r++) begin
      runRow(r);
    end
    $display("Tests run: %0d, checks: %0d, errors: %0d", numRows, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Bound on the whole run
  initial begin
    #(numRows * rowCycles * clkPeriod);
    $display("Watchdog expired: CPU did not halt within %0d cycles per test", rowCycles);
    $display("Tests run: %0d, checks: %0d, errors: %0d", numRows, checkCount, errorCount);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule
